/* build.f */
common/SchedulerPkg.sv
common/ActiveListPkg.sv
wakeup/WakeupPipe.sv
wakeup/FlushRangeTracker.sv
wakeup/WakeupPipelineRegister.sv
tb/WakeupPipelineTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the wakeup pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module WakeupPipelineTb -o simWakeup
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/simWakeup)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

/* tb/WakeupPipelineTb.sv */
`timescale 1ns/1ps
//====================
// Wakeup pipeline testbench
// Drives select lanes, stalls and recoveries into the wakeup
// pipeline register and checks every output against a cycle model
//====================
module WakeupPipelineTb;
    import SchedulerPkg::*;
    import ActiveListPkg::*;

    localparam int INT_WIDTH = 2;
    localparam int MEM_WIDTH = 2;
    localparam int MEM_LATENCY = 3;
    localparam int LANES = INT_WIDTH + MEM_WIDTH;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = MEM_LATENCY + 2;
    localparam int INT_CYCLES = 10;
    localparam int MEM_CYCLES = 10;
    localparam int MASK_CYCLES = 8;
    localparam int STALL_CYCLES = 14;
    localparam int SEL_CYCLES = 24;
    localparam int FULL_CYCLES = 8;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + INT_CYCLES + MEM_CYCLES + MASK_CYCLES
        + STALL_CYCLES + SEL_CYCLES + FULL_CYCLES + 6 * (DRAIN_CYCLES + 1) + 20;

    typedef struct packed {
        logic valid;
        IssueQueueIndexPath ptr;
        IssueQueueOneHotPath vector;
        ActiveListIndexPath alPtr;
    } StageModel;

    logic clk = 1'b0;
    logic rst;
    logic selected[LANES];
    IssueQueueIndexPath selectedPtr[LANES];
    IssueQueueOneHotPath selectedVector[LANES];
    ActiveListIndexPath selectedActiveListPtr[LANES];
    IssueQueueOneHotPath flushIqEntry;
    logic stall;
    RecoveryKind recoveryKind;
    ActiveListIndexPath flushRangeHead;
    ActiveListIndexPath flushRangeTail;
    logic flushAll;
    logic wakeup[LANES];
    IssueQueueIndexPath wakeupPtr[LANES];
    IssueQueueOneHotPath wakeupVector[LANES];
    logic releaseEntry[LANES];
    IssueQueueIndexPath releasePtr[LANES];
    logic flushedOpExist;

    // Model state, stage 0 is the exit stage
    StageModel mStage[LANES][MEM_LATENCY];
    int mCount[2];
    ActiveListIndexPath mHead;
    ActiveListIndexPath mTail;
    logic mAll;

    logic [31:0] lcgState = 32'd78158;
    string testName = "reset";
    int errorCount = 0;
    int errorsAtStart = 0;
    int passCount = 0;
    int failCount = 0;
    int cycleCount = 0;

    WakeupPipelineRegister #(
        .intIssueWidth(INT_WIDTH),
        .memIssueWidth(MEM_WIDTH),
        .memLatency(MEM_LATENCY)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .selected(selected),
        .selectedPtr(selectedPtr),
        .selectedVector(selectedVector),
        .selectedActiveListPtr(selectedActiveListPtr),
        .flushIqEntry(flushIqEntry),
        .stall(stall),
        .recoveryKind(recoveryKind),
        .flushRangeHead(flushRangeHead),
        .flushRangeTail(flushRangeTail),
        .flushAll(flushAll),
        .wakeup(wakeup),
        .wakeupPtr(wakeupPtr),
        .wakeupVector(wakeupVector),
        .releaseEntry(releaseEntry),
        .releasePtr(releasePtr),
        .flushedOpExist(flushedOpExist)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic int laneLatency(input int lane);
        return (lane < INT_WIDTH) ? 1 : MEM_LATENCY;
    endfunction

    // Circular [head, tail) membership
    function automatic bit rangeHit(input ActiveListIndexPath head,
        input ActiveListIndexPath tail, input logic all, input ActiveListIndexPath ptr);
        if (all) begin
            return 1'b1;
        end
        if (head <= tail) begin
            return (ptr >= head) && (ptr < tail);
        end
        return (ptr >= head) || (ptr < tail);
    endfunction

    // Advances the model by one clock edge with the inputs of this cycle
    function automatic void stepModel();
        StageModel entry;
        int lat;
        for (int l = 0; l < LANES; l++) begin
            lat = laneLatency(l);
            entry.valid = selected[l] && !flushIqEntry[selectedPtr[l]];
            entry.ptr = selectedPtr[l];
            entry.vector = entry.valid ? selectedVector[l] : '0;
            entry.alPtr = selectedActiveListPtr[l];
            if (!stall) begin
                for (int j = 0; j < lat - 1; j++) begin
                    mStage[l][j] = mStage[l][j+1];
                end
                mStage[l][lat-1] = entry;
            end
            else if (lat > 1) begin
                for (int j = 0; j < lat - 2; j++) begin
                    mStage[l][j] = mStage[l][j+1];
                end
                mStage[l][lat-2] = '0;
            end
            if (rst || recoveryKind == recoveryFull) begin
                for (int j = 0; j < lat; j++) begin
                    mStage[l][j].valid = 1'b0;
                end
            end
        end
        if (recoveryKind == recoverySelective) begin
            mHead = flushRangeHead;
            mTail = flushRangeTail;
            mAll = flushAll;
        end
        for (int p = 0; p < 2; p++) begin
            if (rst) begin
                mCount[p] = 0;
            end
            else if (recoveryKind == recoverySelective) begin
                mCount[p] = (p == 0) ? 1 : MEM_LATENCY;
            end
            else if (mCount[p] == ((p == 0) ? 1 : MEM_LATENCY)) begin
                mCount[p] = stall ? mCount[p] : mCount[p] - 1;
            end
            else if (mCount[p] > 0) begin
                mCount[p] = mCount[p] - 1;
            end
        end
    endfunction

    task automatic reportValue(input string what, input logic [31:0] expected,
        input logic [31:0] actual);
        $display("** Error %s: %s expected %h actual %h", testName, what, expected, actual);
        errorCount++;
    endtask

    task automatic compareOutputs();
        StageModel exitStage;
        logic gate;
        logic flush;
        logic expWake;
        logic expRel;
        IssueQueueOneHotPath expVector;
        int p;
        for (int l = 0; l < LANES; l++) begin
            exitStage = mStage[l][0];
            p = (l < INT_WIDTH) ? 0 : 1;
            gate = (laneLatency(l) == 1) && stall;
            flush = (mCount[p] != 0) && rangeHit(mHead, mTail, mAll, exitStage.alPtr);
            expWake = exitStage.valid && !flush && !gate;
            expRel = exitStage.valid && !gate;
            expVector = gate ? '0 : exitStage.vector;
            if (wakeup[l] !== expWake) begin
                reportValue($sformatf("wakeup[%0d]", l), 32'(expWake), 32'(wakeup[l]));
            end
            if (releaseEntry[l] !== expRel) begin
                reportValue($sformatf("releaseEntry[%0d]", l), 32'(expRel),
                    32'(releaseEntry[l]));
            end
            if (expRel && releasePtr[l] !== exitStage.ptr) begin
                reportValue($sformatf("releasePtr[%0d]", l), 32'(exitStage.ptr),
                    32'(releasePtr[l]));
            end
            if (expWake && wakeupPtr[l] !== exitStage.ptr) begin
                reportValue($sformatf("wakeupPtr[%0d]", l), 32'(exitStage.ptr),
                    32'(wakeupPtr[l]));
            end
            // Masked entries and bubbles carry a zero vector
            if (!rst && wakeupVector[l] !== expVector) begin
                reportValue($sformatf("wakeupVector[%0d]", l), 32'(expVector),
                    32'(wakeupVector[l]));
            end
        end
        if (flushedOpExist !== ((mCount[0] != 0) || (mCount[1] != 0))) begin
            reportValue("flushedOpExist", 32'((mCount[0] != 0) || (mCount[1] != 0)),
                32'(flushedOpExist));
        end
    endtask

    always @(posedge clk) begin
        stepModel();
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        compareOutputs();
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic clearInputs();
        for (int l = 0; l < LANES; l++) begin
            selected[l] = 1'b0;
            selectedPtr[l] = '0;
            selectedVector[l] = '0;
            selectedActiveListPtr[l] = '0;
        end
        flushIqEntry = '0;
        stall = 1'b0;
        recoveryKind = recoveryNone;
        flushRangeHead = '0;
        flushRangeTail = '0;
        flushAll = 1'b0;
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
        clearInputs();
    endtask

    task automatic selectOp(input int lane);
        logic [31:0] r;
        r = nextRandom();
        selectedPtr[lane] = r[27:24];
        r = nextRandom();
        selectedVector[lane] = r[31:16];
        r = nextRandom();
        selectedActiveListPtr[lane] = r[29:24];
        selected[lane] = 1'b1;
    endtask

    task automatic selectAll();
        for (int l = 0; l < LANES; l++) begin
            selectOp(l);
        end
    endtask

    task automatic selectiveFlush(input ActiveListIndexPath head,
        input ActiveListIndexPath tail, input logic all);
        recoveryKind = recoverySelective;
        flushRangeHead = head;
        flushRangeTail = tail;
        flushAll = all;
    endtask

    task automatic startTest(input string name);
        testName = name;
        errorsAtStart = errorCount;
    endtask

    task automatic finishTest();
        repeat (DRAIN_CYCLES) nextCycle();
        @(negedge clk);
        #1;
        if (errorCount == errorsAtStart) begin
            passCount++;
            $display("Test %s: passed", testName);
        end
        else begin
            failCount++;
            $display("Test %s: failed with %0d errors", testName, errorCount - errorsAtStart);
        end
    endtask

    initial begin
        for (int l = 0; l < LANES; l++) begin
            for (int j = 0; j < MEM_LATENCY; j++) begin
                mStage[l][j] = '0;
            end
        end
        mCount[0] = 0;
        mCount[1] = 0;
        mHead = '0;
        mTail = '0;
        mAll = 1'b0;
        clearInputs();
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        startTest("intSelect");
        for (int c = 0; c < INT_CYCLES; c++) begin
            nextCycle();
            selectOp(0);
            if (c % 2 == 1) begin
                selectOp(1);
            end
        end
        finishTest();

        startTest("memBackToBack");
        for (int c = 0; c < MEM_CYCLES; c++) begin
            nextCycle();
            selectOp(2);
            if (c != 4) begin
                selectOp(3);
            end
        end
        finishTest();

        startTest("entryMask");
        for (int c = 0; c < MASK_CYCLES; c++) begin
            nextCycle();
            selectAll();
            flushIqEntry[selectedPtr[0]] = 1'b1;
            flushIqEntry[selectedPtr[2]] = 1'b1;
            if (c % 2 == 1) begin
                flushIqEntry[selectedPtr[3]] = 1'b1;
            end
        end
        finishTest();

        startTest("stallHold");
        for (int c = 0; c < STALL_CYCLES; c++) begin
            nextCycle();
            selectAll();
            stall = (c == 3) || (c == 4) || (c == 8);
        end
        finishTest();

        startTest("selectiveRecovery");
        for (int c = 0; c < SEL_CYCLES; c++) begin
            nextCycle();
            selectAll();
            case (c)
                2: selectiveFlush(6'd8, 6'd40, 1'b0);
                9: selectiveFlush(6'd50, 6'd20, 1'b0);
                10, 11: stall = 1'b1;
                16: selectiveFlush(6'd0, 6'd0, 1'b1);
                20: selectiveFlush(6'd30, 6'd30, 1'b0);
                default: ;
            endcase
        end
        finishTest();

        startTest("fullRecovery");
        for (int c = 0; c < FULL_CYCLES; c++) begin
            nextCycle();
            if (c < 4) begin
                selectAll();
            end
            if (c == 3) begin
                recoveryKind = recoveryFull;
            end
        end
        finishTest();

        $display("Tests passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end
        else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : WakeupPipelineTb

/* wakeup/WakeupPipelineRegister.sv */
`timescale 1ns/1ps
//====================
// Wakeup pipeline register
// Splits the select lanes into the int and mem pipes and
// applies full and selective recovery to both
//====================
module WakeupPipelineRegister #(
    parameter int intIssueWidth = 2,
    parameter int memIssueWidth = 2,
    parameter int memLatency = 3
) (
    input  logic clk,
    input  logic rst,
    input  logic selected[intIssueWidth+memIssueWidth],
    input  SchedulerPkg::IssueQueueIndexPath selectedPtr[intIssueWidth+memIssueWidth],
    input  SchedulerPkg::IssueQueueOneHotPath selectedVector[intIssueWidth+memIssueWidth],
    input  ActiveListPkg::ActiveListIndexPath
        selectedActiveListPtr[intIssueWidth+memIssueWidth],
    input  SchedulerPkg::IssueQueueOneHotPath flushIqEntry,
    input  logic stall,
    input  SchedulerPkg::RecoveryKind recoveryKind,
    input  ActiveListPkg::ActiveListIndexPath flushRangeHead,
    input  ActiveListPkg::ActiveListIndexPath flushRangeTail,
    input  logic flushAll,
    output logic wakeup[intIssueWidth+memIssueWidth],
    output SchedulerPkg::IssueQueueIndexPath wakeupPtr[intIssueWidth+memIssueWidth],
    output SchedulerPkg::IssueQueueOneHotPath wakeupVector[intIssueWidth+memIssueWidth],
    output logic releaseEntry[intIssueWidth+memIssueWidth],
    output SchedulerPkg::IssueQueueIndexPath releasePtr[intIssueWidth+memIssueWidth],
    output logic flushedOpExist
);
    import SchedulerPkg::*;
    import ActiveListPkg::*;

    // Int lanes come first, mem lanes follow
    localparam int intLast = intIssueWidth - 1;
    localparam int memFirst = intIssueWidth;
    localparam int memLast = intIssueWidth + memIssueWidth - 1;

    logic fullFlush;
    ActiveListIndexPath intExitPtr[intIssueWidth];
    ActiveListIndexPath memExitPtr[memIssueWidth];
    logic intFlush[intIssueWidth];
    logic memFlush[memIssueWidth];

    assign fullFlush = (recoveryKind == recoveryFull);

    WakeupPipe #(
        .laneCount(intIssueWidth),
        .latency(1)
    ) intPipe (
        .clk(clk),
        .rst(rst),
        .fullFlush(fullFlush),
        .stall(stall),
        .flushIqEntry(flushIqEntry),
        .selected(selected[0:intLast]),
        .selectedPtr(selectedPtr[0:intLast]),
        .selectedVector(selectedVector[0:intLast]),
        .selectedActiveListPtr(selectedActiveListPtr[0:intLast]),
        .laneFlush(intFlush),
        .exitActiveListPtr(intExitPtr),
        .wakeup(wakeup[0:intLast]),
        .wakeupPtr(wakeupPtr[0:intLast]),
        .wakeupVector(wakeupVector[0:intLast]),
        .releaseEntry(releaseEntry[0:intLast]),
        .releasePtr(releasePtr[0:intLast])
    );

    WakeupPipe #(
        .laneCount(memIssueWidth),
        .latency(memLatency)
    ) memPipe (
        .clk(clk),
        .rst(rst),
        .fullFlush(fullFlush),
        .stall(stall),
        .flushIqEntry(flushIqEntry),
        .selected(selected[memFirst:memLast]),
        .selectedPtr(selectedPtr[memFirst:memLast]),
        .selectedVector(selectedVector[memFirst:memLast]),
        .selectedActiveListPtr(selectedActiveListPtr[memFirst:memLast]),
        .laneFlush(memFlush),
        .exitActiveListPtr(memExitPtr),
        .wakeup(wakeup[memFirst:memLast]),
        .wakeupPtr(wakeupPtr[memFirst:memLast]),
        .wakeupVector(wakeupVector[memFirst:memLast]),
        .releaseEntry(releaseEntry[memFirst:memLast]),
        .releasePtr(releasePtr[memFirst:memLast])
    );

    FlushRangeTracker #(
        .intIssueWidth(intIssueWidth),
        .memIssueWidth(memIssueWidth),
        .memLatency(memLatency)
    ) flushTracker (
        .clk(clk),
        .rst(rst),
        .recoveryKind(recoveryKind),
        .flushRangeHead(flushRangeHead),
        .flushRangeTail(flushRangeTail),
        .flushAll(flushAll),
        .stall(stall),
        .intExitPtr(intExitPtr),
        .memExitPtr(memExitPtr),
        .intFlush(intFlush),
        .memFlush(memFlush),
        .flushedOpExist(flushedOpExist)
    );

endmodule : WakeupPipelineRegister

/* wakeup/FlushRangeTracker.sv */
`timescale 1ns/1ps
//====================
// Flush range tracker
// Holds the selective flush range and counts how many pipe stages
// may still carry ops from that range
//====================
module FlushRangeTracker #(
    parameter int intIssueWidth = 2,
    parameter int memIssueWidth = 2,
    parameter int memLatency = 3
) (
    input  logic clk,
    input  logic rst,
    input  SchedulerPkg::RecoveryKind recoveryKind,
    input  ActiveListPkg::ActiveListIndexPath flushRangeHead,
    input  ActiveListPkg::ActiveListIndexPath flushRangeTail,
    input  logic flushAll,
    input  logic stall,
    input  ActiveListPkg::ActiveListIndexPath intExitPtr[intIssueWidth],
    input  ActiveListPkg::ActiveListIndexPath memExitPtr[memIssueWidth],
    output logic intFlush[intIssueWidth],
    output logic memFlush[memIssueWidth],
    output logic flushedOpExist
);
    import SchedulerPkg::*;
    import ActiveListPkg::*;

    localparam int intLatency = 1;

    typedef logic [$clog2(intLatency):0] IntCount;
    typedef logic [$clog2(memLatency):0] MemCount;

    ActiveListIndexPath rangeHead;
    ActiveListIndexPath rangeTail;
    logic rangeAll;
    logic selectiveRecovery;

    // Stages of each pipe that may still hold a flushed op
    IntCount intCount;
    MemCount memCount;

    assign selectiveRecovery = (recoveryKind == recoverySelective);

    always_ff @(posedge clk) begin
        if (selectiveRecovery) begin
            rangeHead <= flushRangeHead;
            rangeTail <= flushRangeTail;
            rangeAll <= flushAll;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            intCount <= '0;
            memCount <= '0;
        end
        else if (selectiveRecovery) begin
            intCount <= IntCount'(intLatency);
            memCount <= MemCount'(memLatency);
        end
        else begin
            // The newest stage only moves on when the scheduler is not stalled
            if (intCount == IntCount'(intLatency)) begin
                if (!stall) begin
                    intCount <= intCount - IntCount'(1);
                end
            end
            else if (intCount != '0) begin
                intCount <= intCount - IntCount'(1);
            end

            if (memCount == MemCount'(memLatency)) begin
                if (!stall) begin
                    memCount <= memCount - MemCount'(1);
                end
            end
            else if (memCount != '0) begin
                memCount <= memCount - MemCount'(1);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < intIssueWidth; i++) begin
            intFlush[i] = (intCount != '0) &&
                InFlushRange(rangeHead, rangeTail, rangeAll, intExitPtr[i]);
        end
        for (int i = 0; i < memIssueWidth; i++) begin
            memFlush[i] = (memCount != '0) &&
                InFlushRange(rangeHead, rangeTail, rangeAll, memExitPtr[i]);
        end
        flushedOpExist = (intCount != '0) || (memCount != '0);
    end

    countBound: assert property (@(posedge clk) disable iff (rst)
        (intCount <= IntCount'(intLatency)) && (memCount <= MemCount'(memLatency)))
        else $error("Flush window counter beyond pipe latency");

endmodule : FlushRangeTracker

/* wakeup/WakeupPipe.sv */
`timescale 1ns/1ps
//====================
// Wakeup pipe
// Carries the selected ops of one issue pipe for its latency, then
// wakes their consumers and releases their issue-queue entries
//====================
module WakeupPipe #(
    parameter int laneCount = 1,
    parameter int latency = 1
) (
    input  logic clk,
    input  logic rst,
    input  logic fullFlush,
    input  logic stall,
    input  SchedulerPkg::IssueQueueOneHotPath flushIqEntry,
    input  logic selected[laneCount],
    input  SchedulerPkg::IssueQueueIndexPath selectedPtr[laneCount],
    input  SchedulerPkg::IssueQueueOneHotPath selectedVector[laneCount],
    input  ActiveListPkg::ActiveListIndexPath selectedActiveListPtr[laneCount],
    input  logic laneFlush[laneCount],
    output ActiveListPkg::ActiveListIndexPath exitActiveListPtr[laneCount],
    output logic wakeup[laneCount],
    output SchedulerPkg::IssueQueueIndexPath wakeupPtr[laneCount],
    output SchedulerPkg::IssueQueueOneHotPath wakeupVector[laneCount],
    output logic releaseEntry[laneCount],
    output SchedulerPkg::IssueQueueIndexPath releasePtr[laneCount]
);
    import SchedulerPkg::*;
    import ActiveListPkg::*;

    // A single stage is held during stall, so its exit must be gated
    localparam bit stallGated = (latency == 1);

    // Stage latency-1 takes new ops, stage 0 is the one leaving
    logic stageValid[laneCount][latency];
    IssueQueueIndexPath stagePtr[laneCount][latency];
    IssueQueueOneHotPath stageVector[laneCount][latency];
    ActiveListIndexPath stageActiveListPtr[laneCount][latency];

    logic entryValid[laneCount];
    IssueQueueOneHotPath entryVector[laneCount];
    logic exitGate;

    always_comb begin
        for (int i = 0; i < laneCount; i++) begin
            // Ops whose entry is flushed this cycle enter as bubbles
            entryValid[i] = selected[i] && !flushIqEntry[selectedPtr[i]];
            entryVector[i] = flushIqEntry[selectedPtr[i]] ? '0 : selectedVector[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || fullFlush) begin
            for (int i = 0; i < laneCount; i++) begin
                for (int j = 0; j < latency; j++) begin
                    stageValid[i][j] <= 1'b0;
                end
            end
        end
        else begin
            for (int i = 0; i < laneCount; i++) begin
                for (int j = 0; j < latency; j++) begin
                    if (j == latency - 1) begin
                        if (!stall) begin
                            stageValid[i][j] <= entryValid[i];
                        end
                    end
                    else if (!stall || j < latency - 2) begin
                        stageValid[i][j] <= stageValid[i][j+1];
                    end
                    else begin
                        // Newest stage holds, the one behind it gets a bubble
                        stageValid[i][j] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < laneCount; i++) begin
            for (int j = 0; j < latency; j++) begin
                if (j == latency - 1) begin
                    if (!stall) begin
                        stagePtr[i][j] <= selectedPtr[i];
                        stageVector[i][j] <= entryVector[i];
                        stageActiveListPtr[i][j] <= selectedActiveListPtr[i];
                    end
                end
                else if (!stall || j < latency - 2) begin
                    stagePtr[i][j] <= stagePtr[i][j+1];
                    stageVector[i][j] <= stageVector[i][j+1];
                    stageActiveListPtr[i][j] <= stageActiveListPtr[i][j+1];
                end
                else begin
                    stageVector[i][j] <= '0;
                end
            end
        end
    end

    always_comb begin
        exitGate = stallGated && stall;
        for (int i = 0; i < laneCount; i++) begin
            exitActiveListPtr[i] = stageActiveListPtr[i][0];
            // Selectively flushed ops still free their entry
            wakeup[i] = stageValid[i][0] && !laneFlush[i] && !exitGate;
            wakeupPtr[i] = stagePtr[i][0];
            wakeupVector[i] = exitGate ? '0 : stageVector[i][0];
            releaseEntry[i] = stageValid[i][0] && !exitGate;
            releasePtr[i] = stagePtr[i][0];
        end
    end

    latencyCheck: assert property (@(posedge clk) latency >= 1)
        else $error("WakeupPipe latency must be at least 1");

    for (genvar i = 0; i < laneCount; i++) begin : gLaneCheck
        // A woken op always frees its entry in the same cycle
        wakeupReleases: assert property (@(posedge clk) disable iff (rst)
            wakeup[i] |-> releaseEntry[i])
            else $error("Lane %0d woke up without releasing its entry", i);
    end

endmodule : WakeupPipe

/* common/ActiveListPkg.sv */
//====================
// Active list package
// Active-list size, pointer type and the circular
// flush-range membership test
//====================
package ActiveListPkg;

    localparam int ACTIVE_LIST_ENTRY_NUM = 64;
    localparam int ACTIVE_LIST_INDEX_BIT_SIZE = $clog2(ACTIVE_LIST_ENTRY_NUM);

    typedef logic [ACTIVE_LIST_INDEX_BIT_SIZE-1:0] ActiveListIndexPath;

    // True when ptr lies in [head, tail) of the circular list
    function automatic logic InFlushRange(
        input ActiveListIndexPath head,
        input ActiveListIndexPath tail,
        input logic flushAll,
        input ActiveListIndexPath ptr
    );
        logic inRange;
        if (flushAll) begin
            inRange = 1'b1;
        end
        else if (head <= tail) begin
            inRange = (ptr >= head) && (ptr < tail);
        end
        else begin
            // Range wraps past the last entry
            inRange = (ptr >= head) || (ptr < tail);
        end
        return inRange;
    endfunction

endpackage : ActiveListPkg

/* common/SchedulerPkg.sv */
//====================
// Scheduler package
// Issue-queue sizes, entry pointer and producer vector types,
// and the kinds of recovery request seen by the scheduler
//====================
package SchedulerPkg;

    localparam int ISSUE_QUEUE_ENTRY_NUM = 16;
    localparam int ISSUE_QUEUE_INDEX_BIT_SIZE = $clog2(ISSUE_QUEUE_ENTRY_NUM);

    // Pointer to one issue-queue entry
    typedef logic [ISSUE_QUEUE_INDEX_BIT_SIZE-1:0] IssueQueueIndexPath;

    // One bit per entry, used for producer vectors and flush sets
    typedef logic [ISSUE_QUEUE_ENTRY_NUM-1:0] IssueQueueOneHotPath;

    // Recovery request of the current cycle
    typedef enum logic [1:0] {
        recoveryNone      = 2'b00,
        recoveryFull      = 2'b01,  // from a stage before RW, drops everything
        recoverySelective = 2'b10   // from the RW stage, with a flush range
    } RecoveryKind;

endpackage : SchedulerPkg
